/* hw/ppu_pkg.sv */
package ppu_pkg;

	// Horizontal frame layout in dots.
	localparam logic [9:0] dots_per_line = 10'd341;
	localparam logic [9:0] visible_dots = 10'd256;

	// Window in which the first two tiles of the next line are fetched.
	localparam logic [9:0] prefetch_first = 10'd320;
	localparam logic [9:0] prefetch_last = 10'd335;

	// Picture lines are 1 to visible_lines.
	localparam logic [9:0] visible_lines = 10'd240;

	localparam logic [15:0] nametable_base = 16'h2000;
	localparam logic [15:0] attribute_base = 16'h23C0;

	// One video RAM address, read as a pattern fetch or as a nametable location.
	typedef union packed {
		struct packed {
			logic [2:0] zero;
			logic bank; // Pattern table half.
			logic [7:0] tile;
			logic plane; // High plane sits 8 bytes above the low one.
			logic [2:0] fine_y;
		} pt;
		struct packed {
			logic [1:0] upper; // Ignored by the memory.
			logic [1:0] region; // Upper bit set for nametable space.
			logic [1:0] nt_select;
			logic [4:0] coarse_y;
			logic [4:0] coarse_x;
		} nt;
	} vram_addr_t;

endpackage

/* hw/ppu_timing.sv */
`timescale 1ns/1ps

module ppu_timing #(
	parameter int lines_per_frame = 262
) (
	input  logic clk,
	input  logic reset,
	input  logic run,
	output logic [9:0] x_idx,
	output logic [9:0] scanline
);

	localparam logic [9:0] last_dot = ppu_pkg::dots_per_line - 10'd1;
	localparam logic [9:0] last_line = 10'(lines_per_frame - 1);

	logic end_of_line;
	logic end_of_frame;

	assign end_of_line = x_idx == last_dot;
	assign end_of_frame = scanline == last_line;

	// Dot counter, advances only while enabled.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			x_idx <= '0;
		end else if (run) begin
			if (end_of_line) begin
				x_idx <= '0;
			end else begin
				x_idx <= x_idx + 10'd1;
			end
		end
	end

	// Line counter steps once per wrap of the dot counter.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			scanline <= '0;
		end else if (run && end_of_line) begin
			if (end_of_frame) begin
				scanline <= '0; // Back to the pre-render line.
			end else begin
				scanline <= scanline + 10'd1;
			end
		end
	end

endmodule

/* hw/ppu_bg.sv */
`timescale 1ns/1ps

module ppu_bg (
	input  logic clk,
	input  logic reset,
	input  logic [7:0] vram_data,
	output logic [15:0] vram_addr,
	output logic [3:0] pixel,
	input  logic [9:0] x_idx,
	input  logic [9:0] scanline,
	input  logic bg_pt_addr,
	input  logic [2:0] fine_x_scroll
);

	logic in_visible;
	logic in_prefetch;
	logic in_active;
	logic [9:0] y_idx; // Picture row being fetched.
	logic [5:0] fetch_col; // Tile column being fetched, up to 33.
	logic [15:0] nt_addr;
	ppu_pkg::vram_addr_t pt_addr;

	logic [7:0] tile_index;
	logic [5:0] at_idx;
	logic next_at_high;
	logic next_at_low;
	logic [7:0] pt_in_low;
	logic [7:0] pt_in_high;

	// Shift registers, bit 0 is the pixel on screen now.
	logic [15:0] pt_low_sr;
	logic [15:0] pt_high_sr;
	logic [8:0] at_low_sr;
	logic [8:0] at_high_sr;

	// Leftmost pattern pixel is bit 7, so it has to land lowest.
	function automatic logic [7:0] bit_reverse(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i] = b[7 - i];
		end
		return r;
	endfunction

	assign in_visible = x_idx < ppu_pkg::visible_dots;
	assign in_prefetch = (x_idx >= ppu_pkg::prefetch_first) &&
		(x_idx <= ppu_pkg::prefetch_last);
	assign in_active = in_visible || in_prefetch;

	// The prefetch works on the row of the coming line.
	assign y_idx = in_visible ? scanline - 10'd1 : scanline;

	// Two tiles ahead while drawing, tiles 0 and 1 during the prefetch.
	assign fetch_col = in_visible ? {1'b0, x_idx[7:3]} + 6'd2 : {5'd0, x_idx[3]};

	// Flat offset, so columns 32 and 33 spill into the next row.
	assign nt_addr = ppu_pkg::nametable_base + {4'd0, y_idx[9:3], 5'd0} +
		{10'd0, fetch_col};

	always_comb begin
		pt_addr = '0;
		pt_addr.pt.bank = bg_pt_addr;
		pt_addr.pt.tile = tile_index;
		pt_addr.pt.plane = x_idx[0]; // Low plane in phase 4, high in phase 5.
		pt_addr.pt.fine_y = y_idx[2:0];
	end

	assign pixel = {at_high_sr[fine_x_scroll], at_low_sr[fine_x_scroll],
		pt_high_sr[fine_x_scroll], pt_low_sr[fine_x_scroll]};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			vram_addr <= '0;
			tile_index <= '0;
			at_idx <= '0;
			next_at_high <= 1'b0;
			next_at_low <= 1'b0;
			pt_in_low <= '0;
			pt_in_high <= '0;
			pt_low_sr <= '0;
			pt_high_sr <= '0;
			at_low_sr <= '0;
			at_high_sr <= '0;
		end else if (in_active) begin
			// Top bit holds, so the attribute fills in behind the shift.
			pt_low_sr <= {pt_low_sr[15], pt_low_sr[15:1]};
			pt_high_sr <= {pt_high_sr[15], pt_high_sr[15:1]};
			at_low_sr <= {at_low_sr[8], at_low_sr[8:1]};
			at_high_sr <= {at_high_sr[8], at_high_sr[8:1]};

			case (x_idx[2:0])
				3'd0: vram_addr <= nt_addr;
				3'd1: begin
					tile_index <= vram_data;
					at_idx <= {y_idx[7:5], fetch_col[4:2]}; // 32 by 32 block.
				end
				3'd2: vram_addr <= ppu_pkg::attribute_base + {10'd0, at_idx};
				3'd3: begin
					// Quadrant within the block.
					case ({y_idx[4], fetch_col[1]})
						2'b11: {next_at_high, next_at_low} <= vram_data[7:6];
						2'b10: {next_at_high, next_at_low} <= vram_data[5:4];
						2'b01: {next_at_high, next_at_low} <= vram_data[3:2];
						2'b00: {next_at_high, next_at_low} <= vram_data[1:0];
					endcase
				end
				3'd4: vram_addr <= pt_addr;
				3'd5: begin
					pt_in_low <= vram_data;
					vram_addr <= pt_addr;
				end
				3'd6: pt_in_high <= vram_data;
				3'd7: begin
					// Load the new tile above the one now on screen.
					pt_low_sr <= {bit_reverse(pt_in_low), pt_low_sr[8:1]};
					pt_high_sr <= {bit_reverse(pt_in_high), pt_high_sr[8:1]};
					at_low_sr <= {next_at_low, at_low_sr[8:1]};
					at_high_sr <= {next_at_high, at_high_sr[8:1]};
				end
			endcase
		end
	end

endmodule

/* hw/ppu_vram.sv */
`timescale 1ns/1ps

module ppu_vram (
	input  logic clk,
	input  logic reset,
	input  logic [15:0] rd_addr,
	output logic [7:0] rd_data,
	input  logic we,
	input  logic [13:0] waddr,
	input  logic [7:0] wdata
);

	logic [7:0] pt_mem [8192]; // Two 4 KB pattern tables.
	logic [7:0] nt_mem [2048];

	ppu_pkg::vram_addr_t rd_view;
	logic [12:0] pt_index;
	logic [10:0] nt_index;
	logic rd_is_nt;

	assign rd_view = rd_addr;

	assign pt_index = {rd_view.pt.bank, rd_view.pt.tile, rd_view.pt.plane,
		rd_view.pt.fine_y};

	// Upper select bit dropped, so all four nametables mirror onto 2 KB.
	assign nt_index = {rd_view.nt.nt_select[0], rd_view.nt.coarse_y,
		rd_view.nt.coarse_x};

	assign rd_is_nt = rd_view.nt.region[1]; // 0x2000 and up.

	// Read has no latency.
	always_comb begin
		if (rd_is_nt) begin
			rd_data = nt_mem[nt_index];
		end else begin
			rd_data = pt_mem[pt_index];
		end
	end

	// Host port, pattern space below 8192.
	always_ff @(posedge clk) begin
		if (we && !reset) begin // No loads land during reset.
			if (!waddr[13]) begin
				pt_mem[waddr[12:0]] <= wdata;
			end else begin
				nt_mem[waddr[10:0]] <= wdata; // Offset from 8192, modulo 2 KB.
			end
		end
	end

endmodule

/* hw/ppu_palette.sv */
`timescale 1ns/1ps

module ppu_palette (
	input  logic clk,
	input  logic reset,
	input  logic [3:0] pixel,
	input  logic [9:0] x_idx,
	input  logic [9:0] scanline,
	input  logic we,
	input  logic [4:0] waddr,
	input  logic [5:0] wdata,
	output logic [5:0] colour,
	output logic pixel_valid
);

	logic [5:0] pal_mem [32];

	logic [4:0] pal_idx;
	logic visible;

	// Transparent pattern shows the backdrop colour.
	assign pal_idx = (pixel[1:0] == 2'b00) ? 5'd0 : {1'b0, pixel};

	assign visible = (x_idx < ppu_pkg::visible_dots) &&
		(scanline >= 10'd1) &&
		(scanline <= ppu_pkg::visible_lines);

	always_ff @(posedge clk) begin
		if (we) begin
			pal_mem[waddr] <= wdata;
		end
	end

	// One cycle behind the dot it describes.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			colour <= '0;
			pixel_valid <= 1'b0;
		end else begin
			colour <= pal_mem[pal_idx];
			pixel_valid <= visible;
		end
	end

endmodule

/* hw/ppu_bg_top.sv */
`timescale 1ns/1ps

module ppu_bg_top #(
	parameter int lines_per_frame = 262 // NTSC frame.
) (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic bg_pt_addr,
	input  logic [2:0] fine_x_scroll,
	input  logic vram_we,
	input  logic [13:0] vram_waddr,
	input  logic [7:0] vram_wdata,
	input  logic pal_we,
	input  logic [4:0] pal_waddr,
	input  logic [5:0] pal_wdata,
	output logic [9:0] dot,
	output logic [9:0] line,
	output logic [5:0] colour,
	output logic pixel_valid
);

	logic [15:0] vram_addr;
	logic [7:0] vram_data;
	logic [3:0] pixel;

	ppu_timing #(
		.lines_per_frame(lines_per_frame)
	) u_timing (
		.clk(clk),
		.reset(reset),
		.run(run),
		.x_idx(dot),
		.scanline(line)
	);

	ppu_bg u_bg (
		.clk(clk),
		.reset(reset),
		.vram_data(vram_data),
		.vram_addr(vram_addr),
		.pixel(pixel),
		.x_idx(dot),
		.scanline(line),
		.bg_pt_addr(bg_pt_addr),
		.fine_x_scroll(fine_x_scroll)
	);

	ppu_vram u_vram (
		.clk(clk),
		.reset(reset),
		.rd_addr(vram_addr),
		.rd_data(vram_data),
		.we(vram_we),
		.waddr(vram_waddr),
		.wdata(vram_wdata)
	);

	ppu_palette u_palette (
		.clk(clk),
		.reset(reset),
		.pixel(pixel),
		.x_idx(dot),
		.scanline(line),
		.we(pal_we),
		.waddr(pal_waddr),
		.wdata(pal_wdata),
		.colour(colour),
		.pixel_valid(pixel_valid)
	);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int period = 4 // In ns.
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;
		end
	end

endmodule

/* test/ppu_bg_tb.sv */
`timescale 1ns/1ps

module ppu_bg_tb;

	localparam int dots_per_line = 341;
	localparam int lines_per_frame = 262;
	localparam int frame_cycles = dots_per_line * lines_per_frame;
	localparam int load_cycles = 10240 + 32;
	localparam int cycle_limit = load_cycles + 2 * frame_cycles + 1000;

	logic clk;
	logic reset;
	logic run;
	logic bg_pt_addr;
	logic [2:0] fine_x_scroll;
	logic vram_we;
	logic [13:0] vram_waddr;
	logic [7:0] vram_wdata;
	logic pal_we;
	logic [4:0] pal_waddr;
	logic [5:0] pal_wdata;
	logic [9:0] dot;
	logic [9:0] line;
	logic [5:0] colour;
	logic pixel_valid;

	// Copies of everything loaded into the DUT.
	logic [7:0] pt_copy [8192];
	logic [7:0] nt_copy [2048];
	logic [5:0] pal_copy [32];

	logic [7:0] zero_tile; // Blank tile used for nametable row 3.
	logic scroll_set;
	int exp_dot;
	int exp_line;
	int cycle_count = 0;

	tb_clock #(.period(4)) u_clock (.clk(clk));

	ppu_bg_top #(
		.lines_per_frame(lines_per_frame)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.run(run),
		.bg_pt_addr(bg_pt_addr),
		.fine_x_scroll(fine_x_scroll),
		.vram_we(vram_we),
		.vram_waddr(vram_waddr),
		.vram_wdata(vram_wdata),
		.pal_we(pal_we),
		.pal_waddr(pal_waddr),
		.pal_wdata(pal_wdata),
		.dot(dot),
		.line(line),
		.colour(colour),
		.pixel_valid(pixel_valid)
	);

	task automatic compare(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("FAILED at time %0t: %s expected %0d, actual %0d",
				$time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopping on the first mismatch.");
		end
	endtask

	// Expected colour of screen dot x on line l.
	function automatic logic [5:0] model_colour(input int x, input int l,
		input logic [2:0] fx, input logic bank);
		int c;
		int r;
		int sel;
		int pt_off;
		logic [7:0] tile;
		logic [7:0] attr;
		logic [7:0] lo_byte;
		logic [7:0] hi_byte;
		logic [1:0] quad;
		logic [2:0] bit_pos;
		logic [3:0] pix;
		c = x + int'(fx);
		r = l - 1;
		tile = nt_copy[11'((r / 8) * 32 + c / 8)]; // Flat offset that may spill a row.
		attr = nt_copy[11'(int'(ppu_pkg::attribute_base - ppu_pkg::nametable_base) +
			(r / 32) * 8 + (c / 32) % 8)];
		sel = 2 * ((r / 16) % 2) + (c / 16) % 2;
		quad = 2'(attr >> (2 * sel));
		pt_off = int'(bank) * 4096 + int'(tile) * 16 + r % 8;
		lo_byte = pt_copy[13'(pt_off)];
		hi_byte = pt_copy[13'(pt_off + 8)];
		bit_pos = 3'(7 - c % 8);
		pix = {quad, hi_byte[bit_pos], lo_byte[bit_pos]};
		if (pix[1:0] == 2'b00) begin
			return pal_copy[5'd0];
		end
		return pal_copy[{1'b0, pix}];
	endfunction

	// Wait one cycle and check what the DUT shows for the dot just passed.
	task automatic step_cycle();
		int cell_dot;
		int cell_line;
		logic visible;
		logic [5:0] expected;
		@(negedge clk);
		cell_dot = exp_dot;
		cell_line = exp_line;
		if (run) begin
			if (exp_dot == dots_per_line - 1) begin
				exp_dot = 0;
				exp_line = (exp_line == lines_per_frame - 1) ? 0 : exp_line + 1;
			end else begin
				exp_dot = exp_dot + 1;
			end
		end
		compare("dot", 16'(exp_dot), 16'(dot));
		compare("line", 16'(exp_line), 16'(line));
		visible = cell_dot < 256 && cell_line >= 1 && cell_line <= 240;
		compare("pixel_valid", 16'(visible), 16'(pixel_valid));
		if (visible) begin
			// Row 3 shows only the backdrop, whatever its attribute.
			if ((cell_line - 1) / 8 == 3 && cell_dot + int'(fine_x_scroll) < 256) begin
				compare("backdrop colour", 16'(pal_copy[5'd0]), 16'(colour));
			end else begin
				expected = model_colour(cell_dot, cell_line, fine_x_scroll, bg_pt_addr);
				compare("colour", 16'(expected), 16'(colour));
			end
		end
	endtask

	task automatic load_memories();
		logic [7:0] data;
		for (int a = 0; a < 10240; a++) begin
			data = 8'($urandom());
			if (a < 8192) begin
				if ((a % 4096) / 16 == int'(zero_tile)) begin
					data = 8'd0; // Blank tile in both banks.
				end
				pt_copy[13'(a)] = data;
			end else begin
				if (a - 8192 >= 96 && a - 8192 < 128) begin
					data = zero_tile;
				end
				nt_copy[11'(a - 8192)] = data;
			end
			vram_we = 1'b1;
			vram_waddr = 14'(a);
			vram_wdata = data;
			step_cycle();
		end
		vram_we = 1'b0;
		for (int p = 0; p < 32; p++) begin
			pal_copy[5'(p)] = 6'($urandom());
			pal_we = 1'b1;
			pal_waddr = 5'(p);
			pal_wdata = pal_copy[5'(p)];
			step_cycle();
		end
		pal_we = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the test ran for %0d cycles without finishing.", cycle_count);
			$display("Simulation failed");
			$fatal(1, "Timeout.");
		end
	end

	initial begin
		reset = 1'b1;
		run = 1'b0;
		bg_pt_addr = 1'b0;
		fine_x_scroll = 3'd0;
		vram_we = 1'b0;
		vram_waddr = '0;
		vram_wdata = '0;
		pal_we = 1'b0;
		pal_waddr = '0;
		pal_wdata = '0;
		exp_dot = 0;
		exp_line = 0;
		scroll_set = 1'b0;
		void'($urandom(56682));
		zero_tile = 8'($urandom());
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		compare("dot", 16'd0, 16'(dot));
		compare("line", 16'd0, 16'(line));
		compare("colour", 16'd0, 16'(colour));
		compare("pixel_valid", 16'd0, 16'(pixel_valid));
		load_memories();
		run = 1'b1;
		for (int i = 0; i < 2 * frame_cycles; i++) begin
			step_cycle();
			// New scroll and bank for frame two are set in vblank.
			if (!scroll_set && exp_line == 241) begin
				fine_x_scroll = 3'($urandom_range(7, 1));
				bg_pt_addr = 1'b1;
				scroll_set = 1'b1;
			end
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* ppu_bg_top.f */
hw/ppu_pkg.sv
hw/ppu_timing.sv
hw/ppu_bg.sv
hw/ppu_vram.sv
hw/ppu_palette.sv
hw/ppu_bg_top.sv
test/tb_clock.sv
test/ppu_bg_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary -j 0 --top-module ppu_bg_tb -f ppu_bg_top.f -o ppu_bg_sim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/ppu_bg_sim > "$log" 2>&1
cat "$log"

grep -q "Simulation failed" "$log" && exit 1
grep -q "Simulation completed successfully" "$log" || { echo "No result in log"; exit 1; }
exit 0
